// ==== hdl/gem_rx_pkg.sv ====
`default_nettype none

package gem_rx_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int word_w        = 16;  // One decoded word per GEM_RX_CLK160
    localparam int frame_data_w  = 56;  // Words 3..1 plus EOF data byte
    localparam int frames_per_bx = 4;   // Words per frame, one BX

    // --------------------
    // EOF K characters
    // --------------------
    // Normal cycle of four frames
    localparam logic [7:0] k_eof_bc = 8'hBC;
    localparam logic [7:0] k_eof_f7 = 8'hF7;
    localparam logic [7:0] k_eof_fb = 8'hFB;
    localparam logic [7:0] k_eof_fd = 8'hFD;

    localparam logic [7:0] k_ovf_fc    = 8'hFC;  // Overflow, raises latency trigger
    localparam logic [7:0] k_bc0_1c    = 8'h1C;  // BC0 marker
    localparam logic [7:0] k_resync_3c = 8'h3C;  // Resync marker

    // Shown on the payload output while no frame is held
    localparam logic [frame_data_w-1:0] payload_idle = '1;

    // --------------------
    // Word views
    // --------------------
    // Same 16 bits, seen either as plain data or as an EOF word
    typedef union packed {
        logic [word_w-1:0] raw;     // Data word
        struct packed {
            logic [7:0] eof_data;   // High byte carries data
            logic [7:0] k_char;     // Low byte is the comma
        } eof;
    } eof_word_t;

endpackage

`default_nettype wire

// ==== hdl/gem_word_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Classified word stream from the phase tracker
// One word per clock, no back-pressure
interface gem_word_if;
    import gem_rx_pkg::*;

    eof_word_t                word;       // Current received word
    logic                     eof_ok;     // Word is a clean EOF comma
    logic                     data_ok;    // Word is a clean data word
    logic [frames_per_bx-1:0] cew;        // Frame phase strobes, one-hot
    logic                     frame_clr;  // Registered clear

    // Phase tracker side
    modport source (
        output word,
        output eof_ok,
        output data_ok,
        output cew,
        output frame_clr
    );

    // Assembler and link monitor side
    modport sink (
        input word,
        input eof_ok,
        input data_ok,
        input cew,
        input frame_clr
    );

endinterface

`default_nettype wire

// ==== hdl/gem_frame_phase.sv ====
`timescale 1ns/1ns
`default_nettype none

module gem_frame_phase (
    input  wire logic                         GEM_RX_CLK160,
    input  wire logic                         gem_rx_resetdone,
    input  wire logic [gem_rx_pkg::word_w-1:0] rx_data,
    input  wire logic [1:0]                   rx_isk,
    input  wire logic [1:0]                   rx_notintable,
    input  wire logic                         rx_lossofsync,
    input  wire logic                         rx_sync_done,
    input  wire logic                         ttc_resync,
    gem_word_if.source                        wd
);
    import gem_rx_pkg::*;

    logic [frames_per_bx-1:0] cew_q;   // Phase strobe shift register
    logic                     clr_q;   // Registered clear
    logic                     comma;   // K on low byte only
    logic                     clean;   // No sync loss, all symbols in table
    logic                     k_allowed;
    logic                     late_strobe;

    // --------------------
    // Word classification
    // --------------------
    assign comma = (rx_isk == 2'b01);
    assign clean = !rx_lossofsync && (rx_notintable == 2'b00);

    // Allowed EOF markers
    assign k_allowed = rx_data[7:0] inside {k_eof_bc, k_eof_f7, k_eof_fb, k_eof_fd,
                                            k_ovf_fc, k_bc0_1c, k_resync_3c};

    // Overlapping strobes mean a comma arrived early inside the frame
    assign late_strobe = (cew_q[1] && (cew_q[2] || cew_q[3]))  // Word 1 position
                       || (cew_q[2] && cew_q[3]);               // Word 2 position

    assign wd.eof_ok  = clean && comma && k_allowed;
    assign wd.data_ok = clean && (rx_isk == 2'b00) && !late_strobe;

    // --------------------
    // Frame cadence
    // --------------------
    // Comma seen now, so word 1 is next clock
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            cew_q <= '0;
        end else begin
            cew_q[1] <= comma;
            cew_q[2] <= cew_q[1];
            cew_q[3] <= cew_q[2];
            cew_q[0] <= cew_q[3];   // High while the next EOF word is present
        end
    end

    // Clear on lost phase alignment or TTC resync
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            clr_q <= 1'b1;           // Start out cleared
        end else begin
            clr_q <= !rx_sync_done || ttc_resync;
        end
    end

    assign wd.word      = eof_word_t'(rx_data);
    assign wd.cew       = cew_q;
    assign wd.frame_clr = clr_q;

endmodule

`default_nettype wire

// ==== hdl/gem_frame_assembler.sv ====
`timescale 1ns/1ns
`default_nettype none

module gem_frame_assembler (
    input  wire logic                               GEM_RX_CLK160,
    input  wire logic                               gem_rx_resetdone,
    gem_word_if.sink                                wd,
    output logic [gem_rx_pkg::frame_data_w-1:0]     rcv_data,
    output logic [7:0]                              k_char,
    output logic [3:0]                              nonzero_word,
    output logic                                    latency_trig
);
    import gem_rx_pkg::*;

    // Captured words, payload only
    eof_word_t         w0_reg;   // EOF word, read through both views
    logic [word_w-1:0] w1_reg;
    logic [word_w-1:0] w2_reg;

    logic [2:0] nz_acc;          // Nonzero bits for EOF byte, word 1, word 2
    logic       lt_trg_reg;      // Overflow seen on this frame's comma

    // --------------------
    // Word capture
    // --------------------
    always_ff @(posedge GEM_RX_CLK160) begin
        if (!wd.frame_clr) begin
            if (wd.cew[0]) begin
                w0_reg <= wd.word;
            end
            if (wd.cew[1]) begin
                w1_reg <= wd.word.raw;    // First data after the comma
            end
            if (wd.cew[2]) begin
                w2_reg <= wd.word.raw;
            end
        end
    end

    // Per-word flags gathered through the frame
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            nz_acc     <= '0;
            lt_trg_reg <= 1'b0;
        end else if (!wd.frame_clr) begin
            if (wd.cew[0]) begin
                nz_acc[0]  <= |wd.word.eof.eof_data;
                lt_trg_reg <= (wd.word.eof.k_char == k_ovf_fc);   // Overflow marker
            end else if (wd.cew[1]) begin
                nz_acc[1] <= |wd.word.raw;
            end else if (wd.cew[2]) begin
                nz_acc[2] <= |wd.word.raw;
            end
        end
    end

    // --------------------
    // Frame publish
    // --------------------
    // Everything goes out together on the word 3 edge
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            rcv_data     <= payload_idle;
            k_char       <= '0;
            nonzero_word <= '0;
            latency_trig <= 1'b0;
        end else if (wd.frame_clr) begin
            rcv_data     <= payload_idle;
            k_char       <= '0;
            nonzero_word <= '0;
            latency_trig <= 1'b0;
        end else if (wd.cew[3]) begin
            rcv_data     <= {wd.word.raw, w2_reg, w1_reg, w0_reg.eof.eof_data};
            k_char       <= w0_reg.eof.k_char;
            nonzero_word <= {|wd.word.raw, nz_acc};
            latency_trig <= lt_trg_reg;
        end else if (wd.cew == '0) begin
            // Cadence lost, show idle
            rcv_data     <= payload_idle;
            nonzero_word <= '0;
            latency_trig <= 1'b0;
        end
        // Other strobes hold the last frame
    end

endmodule

`default_nettype wire

// ==== hdl/gem_link_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module gem_link_monitor #(
    parameter int good_bx_count = 15,  // Clean frames after the first one
    parameter int err_cnt_w     = 8
) (
    input  wire logic                 GEM_RX_CLK160,
    input  wire logic                 gem_rx_resetdone,
    gem_word_if.sink                  wd,
    output logic                      link_good,
    output logic                      link_had_err,
    output logic                      link_bad,
    output logic [err_cnt_w-1:0]      errcount
);

    localparam int cnt_w = $clog2(good_bx_count + 1);

    // Saturation point, one below all ones
    localparam logic [err_cnt_w-1:0] err_max = {{(err_cnt_w-1){1'b1}}, 1'b0};

    logic [$bits(wd.cew)-1:0] mon_in;     // One ok bit per frame phase
    logic                     mon_rst;    // Last frame not fully clean
    logic [cnt_w-1:0]         mon_count;  // Clean frames since last problem
    logic                     link_err;   // Sticky, link was up and dropped
    logic                     link_went_down;

    assign link_went_down = link_good && mon_rst;   // Up, then a bad frame

    // --------------------
    // Frame health
    // --------------------
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            mon_in    <= '0;
            mon_rst   <= 1'b1;
            mon_count <= '0;
            link_good <= 1'b0;
        end else if (wd.frame_clr) begin
            mon_in    <= '0;
            mon_rst   <= 1'b1;
            mon_count <= '0;
            link_good <= 1'b0;
        end else begin
            if (wd.cew[0]) begin
                mon_in[0] <= wd.eof_ok;                  // Comma and allowed K
            end else if (wd.cew[1]) begin
                mon_in[1] <= wd.data_ok;
            end else if (wd.cew[2]) begin
                mon_in[2] <= wd.data_ok;
            end else if (wd.cew[3]) begin
                mon_in[3] <= wd.data_ok;                 // Frame judged here
            end else begin
                mon_in <= '0;                            // No cadence, link down
            end

            mon_rst <= (mon_in != '1);

            if (mon_rst) begin
                mon_count <= '0;
            end else if (!link_good && wd.cew[3]
                         && (mon_count != cnt_w'(good_bx_count))) begin
                mon_count <= mon_count + 1'b1;
            end

            // Alive after 1 + good_bx_count clean frames
            link_good <= !mon_rst && (mon_count == cnt_w'(good_bx_count));
        end
    end

    // --------------------
    // Loss counting
    // --------------------
    always_ff @(posedge GEM_RX_CLK160 or negedge gem_rx_resetdone) begin
        if (!gem_rx_resetdone) begin
            link_err <= 1'b0;
            errcount <= '0;
        end else if (wd.frame_clr) begin
            link_err <= 1'b0;
            errcount <= '0;
        end else begin
            if (link_went_down) begin
                link_err <= 1'b1;
            end
            if (link_went_down && (errcount != err_max)) begin
                errcount <= errcount + 1'b1;   // Times the link was lost
            end
        end
    end

    assign link_bad     = errcount[err_cnt_w-1];
    assign link_had_err = link_err || mon_rst;  // Also high if never alive

endmodule

`default_nettype wire

// ==== hdl/gem_fiber_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module gem_fiber_rx #(
    parameter int good_bx_count = 15,  // Clean frames needed after the first
    parameter int err_cnt_w     = 8    // Loss counter width, top bit is link_bad
) (
    input  wire logic                                GEM_RX_CLK160,
    input  wire logic                                gem_rx_resetdone,

    // --------------------
    // Decoded stream
    // --------------------
    input  wire logic [gem_rx_pkg::word_w-1:0]       rx_data,
    input  wire logic [1:0]                          rx_isk,         // Per byte K flag
    input  wire logic [1:0]                          rx_notintable,  // Per byte code error
    input  wire logic                                rx_lossofsync,
    input  wire logic                                rx_sync_done,
    input  wire logic                                ttc_resync,     // Clears decoder and monitor

    // --------------------
    // Frame outputs
    // --------------------
    output logic [gem_rx_pkg::frame_data_w-1:0]      rcv_data,
    output logic [7:0]                               k_char,
    output logic [3:0]                               nonzero_word,
    output logic                                     latency_trig,

    // Link status
    output logic                                     link_good,
    output logic                                     link_had_err,
    output logic                                     link_bad,
    output logic [err_cnt_w-1:0]                     errcount
);

    gem_word_if wd ();   // Classified words and phase strobes

    gem_frame_phase i_frame_phase (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .rx_data          (rx_data),
        .rx_isk           (rx_isk),
        .rx_notintable    (rx_notintable),
        .rx_lossofsync    (rx_lossofsync),
        .rx_sync_done     (rx_sync_done),
        .ttc_resync       (ttc_resync),
        .wd               (wd.source)
    );

    gem_frame_assembler i_frame_assembler (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .wd               (wd.sink),
        .rcv_data         (rcv_data),
        .k_char           (k_char),
        .nonzero_word     (nonzero_word),
        .latency_trig     (latency_trig)
    );

    // Link health from the same strobes
    gem_link_monitor #(
        .good_bx_count    (good_bx_count),
        .err_cnt_w        (err_cnt_w)
    ) i_link_monitor (
        .GEM_RX_CLK160    (GEM_RX_CLK160),
        .gem_rx_resetdone (gem_rx_resetdone),
        .wd               (wd.sink),
        .link_good        (link_good),
        .link_had_err     (link_had_err),
        .link_bad         (link_bad),
        .errcount         (errcount)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

// Free running link clock and power-on reset
module tb_clk_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;                          // Transceiver not ready yet
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;                       // Released just after an edge
    end

endmodule

`default_nettype wire

// ==== tb/gem_fiber_rx_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module gem_fiber_rx_sva #(
    parameter int err_cnt_w = 8
) (
    input wire logic                                 GEM_RX_CLK160,
    input wire logic                                 gem_rx_resetdone,
    input wire logic [gem_rx_pkg::frames_per_bx-1:0] cew,
    input wire logic                                 frame_clr,
    input wire logic [gem_rx_pkg::frame_data_w-1:0]  rcv_data,
    input wire logic                                 latency_trig,
    input wire logic                                 link_bad,
    input wire logic [err_cnt_w-1:0]                 errcount
);
    import gem_rx_pkg::*;

    // --------------------
    // Phase and counters
    // --------------------
    cew_onehot: assert property (@(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone)
        $onehot0(cew)) else $error("Phase strobes overlap");

    // Loss counter only moves up between clears
    err_no_drop: assert property (@(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone)
        !$past(frame_clr) |-> (errcount >= $past(errcount)))
        else $error("errcount decreased without a clear");

    // Saturates one below all ones
    err_saturates: assert property (@(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone)
        errcount != '1) else $error("errcount reached all ones");

    // Bad flag only comes up as the counter crosses into its top half
    bad_rises_at_top: assert property (@(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone)
        $rose(link_bad) |-> ($past(errcount) == {1'b0, {(err_cnt_w-1){1'b1}}}))
        else $error("link_bad rose without errcount crossing its top bit");

    // No trigger while no frame is held
    idle_no_trig: assert property (@(posedge GEM_RX_CLK160) disable iff (!gem_rx_resetdone)
        (rcv_data == payload_idle) |-> !latency_trig)
        else $error("latency_trig high on idle payload");

endmodule

bind gem_fiber_rx gem_fiber_rx_sva #(.err_cnt_w(err_cnt_w)) i_sva (
    .GEM_RX_CLK160(GEM_RX_CLK160), .gem_rx_resetdone(gem_rx_resetdone),
    .cew(wd.cew), .frame_clr(wd.frame_clr),  // Internal strobes from the word interface
    .rcv_data(rcv_data), .latency_trig(latency_trig),
    .link_bad(link_bad), .errcount(errcount)
);

`default_nettype wire

// ==== tb/tb_gem_fiber_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_gem_fiber_rx;
    import gem_rx_pkg::*;

    localparam int good_bx_count = 15;
    localparam int err_cnt_w     = 8;
    localparam int max_frames    = 40;  // Timeout for link changes, in frames
    localparam int max_words     = 20;  // Timeout for cadence loss, in words
    localparam logic [7:0] k_list [7] = '{k_eof_bc, k_eof_f7, k_eof_fb, k_eof_fd,
                                          k_ovf_fc, k_bc0_1c, k_resync_3c};

    logic clk, rst_n;
    logic [word_w-1:0] rx_data;
    logic [1:0] rx_isk, rx_notintable;
    logic rx_lossofsync, rx_sync_done, ttc_resync;
    logic [frame_data_w-1:0] rcv_data;
    logic [7:0] k_char;
    logic [3:0] nonzero_word;
    logic latency_trig, link_good, link_had_err, link_bad;
    logic [err_cnt_w-1:0] errcount;

    logic [15:0] lfsr_state;
    string       test_name;
    // Last frame sent, checked one clock after its word 3
    logic pend_valid;
    logic [frame_data_w-1:0] exp_data;
    logic [7:0] exp_k;
    logic [3:0] exp_nz;
    logic exp_lt;

    tb_clk_gen #(.period_ns(10), .reset_cycles(10)) i_clk_gen (.clk(clk), .rst_n(rst_n));

    gem_fiber_rx #(.good_bx_count(good_bx_count), .err_cnt_w(err_cnt_w)) i_dut (
        .GEM_RX_CLK160(clk), .gem_rx_resetdone(rst_n),
        .rx_data(rx_data), .rx_isk(rx_isk), .rx_notintable(rx_notintable),
        .rx_lossofsync(rx_lossofsync), .rx_sync_done(rx_sync_done), .ttc_resync(ttc_resync),
        .rcv_data(rcv_data), .k_char(k_char), .nonzero_word(nonzero_word),
        .latency_trig(latency_trig), .link_good(link_good), .link_had_err(link_had_err),
        .link_bad(link_bad), .errcount(errcount)
    );

    // --------------------
    // Helpers
    // --------------------
    task automatic check_value(input string field, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s %s expected %h actual %h", test_name, field,
                     expected, actual);
            $display("Verification failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("%s: timed out waiting for %s", test_name, what);
        $display("Verification failed");
        $fatal(1, "Stopped on timeout");
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[14:0], lfsr_state[0]};  // One step per bit
        end
    endtask

    // One word per clock, pending frame checked on the way
    task automatic drive_word(input logic [15:0] data, input logic [1:0] isk,
                              input logic [1:0] nit);
        @(posedge clk);
        #1;
        if (pend_valid) begin
            check_value("rcv_data", exp_data, rcv_data);
            check_value("k_char", exp_k, k_char);
            check_value("nonzero_word", exp_nz, nonzero_word);
            check_value("latency_trig", exp_lt, latency_trig);
            pend_valid = 1'b0;
        end
        rx_data       = data;
        rx_isk        = isk;
        rx_notintable = nit;
    endtask

    // EOF comma, then three data words, bad_pos marks a not-in-table word
    task automatic send_frame(input logic [7:0] k, input logic [7:0] eof_byte,
                              input logic [15:0] w1, input logic [15:0] w2,
                              input logic [15:0] w3, input int bad_pos, input bit do_check);
        drive_word({eof_byte, k}, 2'b01, (bad_pos == 0) ? 2'b01 : 2'b00);
        drive_word(w1, 2'b00, (bad_pos == 1) ? 2'b10 : 2'b00);
        drive_word(w2, 2'b00, (bad_pos == 2) ? 2'b10 : 2'b00);
        drive_word(w3, 2'b00, (bad_pos == 3) ? 2'b10 : 2'b00);
        if (do_check) begin
            exp_data   = {w3, w2, w1, eof_byte};
            exp_k      = k;
            exp_nz     = {w3 != 0, w2 != 0, w1 != 0, eof_byte != 0};
            exp_lt     = (k == 8'hFC);              // Overflow marker
            pend_valid = 1'b1;
        end
    endtask

    // zero_mask bits are EOF byte, word 1, word 2, word 3
    task automatic send_random_frame(input logic [7:0] k, input logic [3:0] zero_mask,
                                     input bit do_check);
        logic [15:0] eof_byte, w1, w2, w3;
        random_bits(8, eof_byte);
        random_bits(16, w1);
        random_bits(16, w2);
        random_bits(16, w3);
        send_frame(k, zero_mask[0] ? 8'h00 : eof_byte[7:0], zero_mask[1] ? 16'h0 : w1,
                   zero_mask[2] ? 16'h0 : w2, zero_mask[3] ? 16'h0 : w3, -1, do_check);
    endtask

    task automatic check_idle_state();
        check_value("rcv_data", {frame_data_w{1'b1}}, rcv_data);
        check_value("latency_trig", 1'b0, latency_trig);
        check_value("link_good", 1'b0, link_good);
        check_value("link_had_err", 1'b1, link_had_err);  // Never alive since clear
        check_value("errcount", '0, errcount);
        check_value("link_bad", 1'b0, link_bad);
    endtask

    // Clear is registered, outputs follow one edge later
    task automatic pulse_resync();
        drive_word(16'h0000, 2'b00, 2'b00);
        ttc_resync = 1'b1;
        @(posedge clk);
        #1 ttc_resync = 1'b0;
        @(posedge clk);
        #1;
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_reset_state();
        int n;
        test_name = "reset_state";
        for (n = 0; n < 50 && !rst_n; n++) begin
            @(posedge clk);
        end
        if (!rst_n) fail_timeout("reset release");
        @(posedge clk);
        #1 check_idle_state();
        send_frame(k_eof_bc, 8'h5A, 16'h1234, 16'h5678, 16'h9ABC, -1, 1'b0);
        send_frame(k_ovf_fc, 8'hA5, 16'h4321, 16'h8765, 16'hCBA9, -1, 1'b0);
        pulse_resync();
        check_idle_state();
    endtask

    task automatic test_frame_assembly();
        test_name = "frame_assembly";
        send_random_frame(k_eof_bc, 4'b0000, 1'b0);    // Warm-up, stale EOF byte
        for (int i = 0; i < 10; i++) begin
            send_random_frame(k_list[i % 7], {i == 5, i % 3 == 1, i == 5 || i == 8, i % 4 == 2},
                              1'b1);
        end
        drive_word(16'h0000, 2'b00, 2'b00);            // Flush last check
    endtask

    task automatic test_latency_trig();
        test_name = "latency_trig";
        send_random_frame(k_eof_fd, 4'b0000, 1'b0);
        send_random_frame(k_ovf_fc, 4'b0000, 1'b1);
        send_random_frame(k_eof_bc, 4'b0000, 1'b1);
        send_random_frame(k_ovf_fc, 4'b0000, 1'b1);
        send_random_frame(k_ovf_fc, 4'b0010, 1'b1);
        send_random_frame(k_resync_3c, 4'b0000, 1'b1);
        drive_word(16'h0000, 2'b00, 2'b00);
    endtask

    task automatic test_cadence_loss();
        int n;
        test_name = "cadence_loss";
        send_random_frame(k_eof_f7, 4'b0000, 1'b0);
        send_random_frame(k_ovf_fc, 4'b0000, 1'b1);    // Trigger held until cadence drops
        for (n = 0; n < max_words && rcv_data !== {frame_data_w{1'b1}}; n++) begin
            drive_word(16'h0000, 2'b00, 2'b00);
        end
        if (rcv_data !== {frame_data_w{1'b1}}) fail_timeout("idle payload");
        for (int i = 0; i < 8; i++) begin
            drive_word(16'h0000, 2'b00, 2'b00);
            check_value("rcv_data", {frame_data_w{1'b1}}, rcv_data);
            check_value("latency_trig", 1'b0, latency_trig);
        end
    endtask

    task automatic test_link_up();
        int n;
        test_name = "link_up";
        pulse_resync();
        for (n = 0; n < max_frames && !link_good; n++) begin
            send_random_frame(k_list[n % 7], 4'b0000, 1'b0);
        end
        if (!link_good) fail_timeout("link_good");
        check_value("frames_to_good", 1'b1, n >= good_bx_count + 1);
        check_value("link_had_err", 1'b0, link_had_err);
        check_value("errcount", '0, errcount);
    endtask

    task automatic test_link_loss();
        int n;
        test_name = "link_loss";
        send_frame(k_eof_bc, 8'h11, 16'h2222, 16'h3333, 16'h4444, 1, 1'b0);  // Bad word 1
        for (n = 0; n < 4 && link_good; n++) begin
            send_random_frame(k_eof_bc, 4'b0000, 1'b0);
        end
        if (link_good) fail_timeout("link_good to drop");
        check_value("errcount", 1, errcount);
        check_value("link_had_err", 1'b1, link_had_err);
        send_random_frame(k_eof_fb, 4'b0000, 1'b0);
        check_value("errcount_hold", 1, errcount);   // Counted only once
        pulse_resync();
        check_idle_state();
    endtask

    initial begin
        rx_data       = '0;
        rx_isk        = 2'b00;
        rx_notintable = 2'b00;
        rx_lossofsync = 1'b0;
        rx_sync_done  = 1'b1;
        ttc_resync    = 1'b0;
        pend_valid    = 1'b0;
        lfsr_state    = 16'd2638;
        test_name     = "init";
        test_reset_state();
        test_frame_assembly();
        test_latency_trig();
        test_cadence_loss();
        test_link_up();
        test_link_loss();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/gem_rx_pkg.sv
hdl/gem_word_if.sv
hdl/gem_frame_phase.sv
hdl/gem_frame_assembler.sv
hdl/gem_link_monitor.sv
hdl/gem_fiber_rx.sv
tb/tb_clk_gen.sv
tb/gem_fiber_rx_sva.sv
tb/tb_gem_fiber_rx.sv
